// ==== lsu_cluster_pkg.sv ====
package lsu_cluster_pkg;

  ////////////////////////////////////////////////////////////
  // cluster sizing
  ////////////////////////////////////////////////////////////

  localparam int unsigned NUM_LANES  = 4;          // identical load/store lanes
  localparam int unsigned LANE_IDX_W = 2;          // enough bits to name a lane
  localparam int unsigned TAG_W      = 4;          // operation tag width

  // one access in flight per lane at most, so this never overflows
  localparam int unsigned FIFO_DEPTH = NUM_LANES;

  ////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////

  typedef logic [31:0]           addr_t;      // byte address
  typedef logic [31:0]           word_t;      // data word
  typedef logic [3:0]            be_t;        // one bit per byte lane
  typedef logic [TAG_W-1:0]      tag_t;       // travels with the op to the result
  typedef logic [LANE_IDX_W-1:0] lane_idx_t;  // lane number, also fifo pointer
  typedef logic [1:0]            size_t;      // access size code

  ////////////////////////////////////////////////////////////
  // access size codes
  ////////////////////////////////////////////////////////////

  localparam size_t SIZE_WORD = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_BYTE = 2'd2;  // 2'd3 decodes as byte too

endpackage

// ==== lsu_op_if.sv ====
`timescale 1ns/1ns

// dispatcher -> lane: one operation per start pulse
interface lsu_op_if import lsu_cluster_pkg::*; ();

  logic  start;     // single cycle, from a flop in the dispatcher
  logic  we;        // 1 = store
  size_t size;
  logic  sign_ext;  // loads only
  addr_t addr;      // effective address, already summed
  word_t wdata;     // store data in the low bits
  tag_t  tag;
  logic  busy;      // lane level, start cycle through final rvalid

  modport disp (
    output start, we, size, sign_ext, addr, wdata, tag,
    input  busy
  );

  modport lane (
    input  start, we, size, sign_ext, addr, wdata, tag,
    output busy
  );

endinterface

// ==== lsu_port_if.sv ====
`timescale 1ns/1ns

// lane <-> arbiter: memory request side plus completion side
interface lsu_port_if import lsu_cluster_pkg::*; ();

  // memory request, held until gnt
  logic  req;
  addr_t addr;
  logic  we;
  be_t   be;
  word_t wdata;

  // memory response, routed per lane by the arbiter
  logic  gnt;
  logic  rvalid;
  logic  err;
  word_t rdata;

  // completion, combinational with the final rvalid
  logic  done;
  word_t result;
  tag_t  res_tag;
  logic  res_err;

  modport lane (
    output req, addr, we, be, wdata, done, result, res_tag, res_err,
    input  gnt, rvalid, err, rdata
  );

  modport arb (
    input  req, addr, we, be, wdata, done, result, res_tag, res_err,
    output gnt, rvalid, err, rdata
  );

endinterface

// ==== lsu_dispatch.sv ====
`timescale 1ns/1ns

module lsu_dispatch import lsu_cluster_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          op_valid_i,
  input  logic          op_we_i,
  input  size_t         op_size_i,
  input  logic          op_sign_ext_i,
  input  addr_t         op_base_i,
  input  addr_t         op_offset_i,
  input  word_t         op_wdata_i,
  input  tag_t          op_tag_i,
  output logic          op_ready_o,
  lsu_op_if.disp        lanes [NUM_LANES]
);

  logic [NUM_LANES-1:0] lane_busy;
  logic [NUM_LANES-1:0] lane_free;  // idle and not being kicked this cycle
  logic [NUM_LANES-1:0] start_d;    // one-hot pick, lowest free lane
  logic [NUM_LANES-1:0] start_q;
  logic                 accept;
  addr_t                eff_addr;

  // op fields, shared by all lanes, sampled by whichever lane sees start
  logic  we_q;
  size_t size_q;
  logic  sext_q;
  addr_t addr_q;
  word_t wdata_q;
  tag_t  tag_q;

  assign eff_addr  = op_base_i + op_offset_i;  // agu
  assign lane_free = ~lane_busy & ~start_q;
  assign op_ready_o = |lane_free;
  assign accept    = op_valid_i & op_ready_o;

  // priority pick, lane 0 wins
  always_comb begin
    start_d = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_free[i] && (start_d == '0)) start_d[i] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= '0;
    end else begin
      start_q <= accept ? start_d : '0;  // pulse lasts one cycle
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      we_q    <= op_we_i;
      size_q  <= op_size_i;
      sext_q  <= op_sign_ext_i;
      addr_q  <= eff_addr;
      wdata_q <= op_wdata_i;
      tag_q   <= op_tag_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // fan out to the lane interfaces
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lanes[g].start    = start_q[g];
    assign lanes[g].we       = we_q;
    assign lanes[g].size     = size_q;
    assign lanes[g].sign_ext = sext_q;
    assign lanes[g].addr     = addr_q;
    assign lanes[g].wdata    = wdata_q;
    assign lanes[g].tag      = tag_q;
    assign lane_busy[g]      = lanes[g].busy;
  end

endmodule

// ==== lsu_lane.sv ====
`timescale 1ns/1ns

module lsu_lane import lsu_cluster_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  lsu_op_if.lane   op,
  lsu_port_if.lane port
);

  typedef enum logic [2:0] {
    IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID
  } lsu_lane_state_e;

  lsu_lane_state_e state_q, state_d;

  // captured operation
  logic      we_q;
  size_t     size_q;
  logic      sext_q;
  addr_t     addr_q;
  word_t     wdata_q;
  tag_t      tag_q;

  logic      part2_q;      // first half of a split access has returned
  logic      err_q;        // err of the first half
  word_t     rdata_q;      // raw word of the first half
  logic      second_part;  // drive second-half address and enables
  logic      req;
  logic      done;
  logic [1:0] off_q;       // byte offset inside the word
  be_t       be;
  word_t     wdata_rot;
  word_t     rdata_ext;

  // word off a word boundary, or halfword straddling bytes 3 and 4
  function automatic logic is_misaligned(input size_t size, input logic [1:0] off);
    return ((size == SIZE_WORD) && (off != 2'b00)) ||
           ((size == SIZE_HALF) && (off == 2'b11));
  endfunction

  assign off_q = addr_q[1:0];

  always_ff @(posedge clk) begin
    if (op.start) begin
      we_q    <= op.we;
      size_q  <= op.size;
      sext_q  <= op.sign_ext;
      addr_q  <= op.addr;
      wdata_q <= op.wdata;
      tag_q   <= op.tag;
    end
    if ((state_q == WAIT_RVALID_MIS) && port.rvalid) rdata_q <= port.rdata;
  end

  ////////////////////////////////////////////////////////////
  // request fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      part2_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (op.start) begin
        part2_q <= 1'b0;
        err_q   <= 1'b0;
      end else if ((state_q == WAIT_RVALID_MIS) && port.rvalid) begin
        part2_q <= 1'b1;
        err_q   <= port.err;  // first half error, or-ed in at the end
      end
    end
  end

  always_comb begin
    state_d = state_q;
    req     = 1'b0;
    done    = 1'b0;
    case (state_q)
      IDLE: begin  // no request yet, req comes the cycle after start
        if (op.start) begin
          state_d = is_misaligned(op.size, op.addr[1:0]) ? WAIT_GNT_MIS : WAIT_GNT;
        end
      end
      WAIT_GNT_MIS: begin
        req = 1'b1;
        if (port.gnt) state_d = WAIT_RVALID_MIS;
      end
      WAIT_RVALID_MIS: begin
        req = port.rvalid;  // second half goes out with first rvalid
        if (port.rvalid) state_d = port.gnt ? WAIT_RVALID : WAIT_GNT;
      end
      WAIT_GNT: begin
        req = 1'b1;
        if (port.gnt) state_d = WAIT_RVALID;
      end
      WAIT_RVALID: begin
        if (port.rvalid) begin
          done    = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign second_part = (state_q == WAIT_RVALID_MIS) | part2_q;

  ////////////////////////////////////////////////////////////
  // byte enables and store data
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (size_q)
      SIZE_WORD: be = second_part ? ~(4'b1111 << off_q) : (4'b1111 << off_q);
      SIZE_HALF: be = second_part ? 4'b0001 : (4'b0011 << off_q);  // top bit drops off
      default:   be = 4'b0001 << off_q;                           // byte
    endcase
  end

  // rotate left by the offset, same data for both halves
  always_comb begin
    case (off_q)
      2'b00:   wdata_rot = wdata_q;
      2'b01:   wdata_rot = {wdata_q[23:0], wdata_q[31:24]};
      2'b10:   wdata_rot = {wdata_q[15:0], wdata_q[31:16]};
      default: wdata_rot = {wdata_q[7:0],  wdata_q[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // load alignment and extension
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [15:0] half;
    logic [7:0]  byte_v;
    word_t       word_v;
    case (off_q)  // words and halfwords, first half from rdata_q when split
      2'b00: begin
        word_v = port.rdata;
        half   = port.rdata[15:0];
      end
      2'b01: begin
        word_v = {port.rdata[7:0], rdata_q[31:8]};
        half   = port.rdata[23:8];
      end
      2'b10: begin
        word_v = {port.rdata[15:0], rdata_q[31:16]};
        half   = port.rdata[31:16];
      end
      default: begin
        word_v = {port.rdata[23:0], rdata_q[31:24]};
        half   = {port.rdata[7:0], rdata_q[31:24]};
      end
    endcase
    byte_v = port.rdata[{off_q, 3'b000} +: 8];
    case (size_q)
      SIZE_WORD: rdata_ext = word_v;
      SIZE_HALF: rdata_ext = sext_q ? {{16{half[15]}}, half} : {16'h0000, half};
      default:   rdata_ext = sext_q ? {{24{byte_v[7]}}, byte_v} : {24'h00_0000, byte_v};
    endcase
  end

  // memory side
  assign port.req   = req;
  assign port.addr  = second_part ? {addr_q[31:2] + 30'd1, 2'b00} : addr_q;  // next word
  assign port.we    = we_q;
  assign port.be    = be;
  assign port.wdata = wdata_rot;

  // completion side
  assign port.done    = done;
  assign port.result  = rdata_ext;
  assign port.res_tag = tag_q;
  assign port.res_err = port.err | err_q;

  assign op.busy = op.start | (state_q != IDLE);

endmodule

// ==== lsu_mem_arbiter.sv ====
`timescale 1ns/1ns

module lsu_mem_arbiter import lsu_cluster_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  lsu_port_if.arb   lanes [NUM_LANES],
  output logic      mem_req_o,
  input  logic      mem_gnt_i,
  output addr_t     mem_addr_o,
  output logic      mem_we_o,
  output be_t       mem_be_o,
  output word_t     mem_wdata_o,
  input  logic      mem_rvalid_i,
  input  logic      mem_err_i,
  input  word_t     mem_rdata_i,
  output logic      res_valid_o,
  output word_t     res_rdata_o,
  output tag_t      res_tag_o,
  output logic      res_err_o
);

  // per-lane views of the interface array
  logic [NUM_LANES-1:0] lane_req, lane_we, lane_done, lane_res_err;
  addr_t                lane_addr   [NUM_LANES];
  be_t                  lane_be     [NUM_LANES];
  word_t                lane_wdata  [NUM_LANES];
  word_t                lane_result [NUM_LANES];
  tag_t                 lane_tag    [NUM_LANES];

  lane_idx_t ptr_q;     // round robin start, one past the last grant
  lane_idx_t sel_rr;    // fresh pick
  lane_idx_t sel_q;     // pick held while stalled
  lane_idx_t sel;
  logic      lock_q;
  logic      push;

  // routing fifo, granted lane indices in grant order
  lane_idx_t fifo_q [FIFO_DEPTH];
  lane_idx_t wr_ptr_q, rd_ptr_q;
  lane_idx_t head;

  ////////////////////////////////////////////////////////////
  // request selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    lane_idx_t idx;
    logic      found;
    sel_rr = ptr_q;
    found  = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      idx = ptr_q + lane_idx_t'(i);  // wraps
      if (!found && lane_req[idx]) begin
        sel_rr = idx;
        found  = 1'b1;
      end
    end
  end

  assign sel       = lock_q ? sel_q : sel_rr;  // keep addr stable under stall
  assign mem_req_o = lane_req[sel];
  assign push      = mem_req_o & mem_gnt_i;

  assign mem_addr_o  = lane_addr[sel];
  assign mem_we_o    = lane_we[sel];
  assign mem_be_o    = lane_be[sel];
  assign mem_wdata_o = lane_wdata[sel];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q    <= '0;
      sel_q    <= '0;
      lock_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        fifo_q[i] <= '0;  // head points at an idle lane until the first grant
      end
    end else begin
      lock_q <= mem_req_o & ~mem_gnt_i;
      sel_q  <= sel;
      if (push) begin
        ptr_q            <= sel + lane_idx_t'(1);
        wr_ptr_q         <= wr_ptr_q + lane_idx_t'(1);
        fifo_q[wr_ptr_q] <= sel;
      end
      if (mem_rvalid_i) rd_ptr_q <= rd_ptr_q + lane_idx_t'(1);  // in-order pop
    end
  end

  assign head = fifo_q[rd_ptr_q];

  ////////////////////////////////////////////////////////////
  // response routing and result merge
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lane_req[g]     = lanes[g].req;
    assign lane_addr[g]    = lanes[g].addr;
    assign lane_we[g]      = lanes[g].we;
    assign lane_be[g]      = lanes[g].be;
    assign lane_wdata[g]   = lanes[g].wdata;
    assign lane_done[g]    = lanes[g].done;
    assign lane_result[g]  = lanes[g].result;
    assign lane_tag[g]     = lanes[g].res_tag;
    assign lane_res_err[g] = lanes[g].res_err;

    assign lanes[g].gnt    = push & (sel == lane_idx_t'(g));
    assign lanes[g].rvalid = mem_rvalid_i & (head == lane_idx_t'(g));
    assign lanes[g].err    = mem_err_i;    // only looked at with rvalid
    assign lanes[g].rdata  = mem_rdata_i;
  end

  // done only rises with that lane's rvalid
  assign res_valid_o = lane_done[head];
  assign res_rdata_o = lane_result[head];
  assign res_tag_o   = lane_tag[head];
  assign res_err_o   = lane_res_err[head];

endmodule

// ==== lsu_cluster_top.sv ====
`timescale 1ns/1ns

module lsu_cluster_top import lsu_cluster_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // execute stage op stream
  input  logic  op_valid_i,
  output logic  op_ready_o,
  input  logic  op_we_i,
  input  size_t op_size_i,
  input  logic  op_sign_ext_i,
  input  addr_t op_base_i,
  input  addr_t op_offset_i,
  input  word_t op_wdata_i,
  input  tag_t  op_tag_i,
  // data memory port
  output logic  mem_req_o,
  input  logic  mem_gnt_i,
  output addr_t mem_addr_o,
  output logic  mem_we_o,
  output be_t   mem_be_o,
  output word_t mem_wdata_o,
  input  logic  mem_rvalid_i,
  input  logic  mem_err_i,
  input  word_t mem_rdata_i,
  // merged completions
  output logic  res_valid_o,
  output word_t res_rdata_o,
  output tag_t  res_tag_o,
  output logic  res_err_o
);

  lsu_op_if   op_if   [NUM_LANES] ();
  lsu_port_if port_if [NUM_LANES] ();

  lsu_dispatch u_dispatch (
    .clk           (clk),
    .rst_n         (rst_n),
    .op_valid_i    (op_valid_i),
    .op_we_i       (op_we_i),
    .op_size_i     (op_size_i),
    .op_sign_ext_i (op_sign_ext_i),
    .op_base_i     (op_base_i),
    .op_offset_i   (op_offset_i),
    .op_wdata_i    (op_wdata_i),
    .op_tag_i      (op_tag_i),
    .op_ready_o    (op_ready_o),
    .lanes         (op_if)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    lsu_lane u_lane (
      .clk   (clk),
      .rst_n (rst_n),
      .op    (op_if[g]),
      .port  (port_if[g])
    );
  end

  lsu_mem_arbiter u_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .lanes        (port_if),
    .mem_req_o    (mem_req_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_addr_o   (mem_addr_o),
    .mem_we_o     (mem_we_o),
    .mem_be_o     (mem_be_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_err_i    (mem_err_i),
    .mem_rdata_i  (mem_rdata_i),
    .res_valid_o  (res_valid_o),
    .res_rdata_o  (res_rdata_o),
    .res_tag_o    (res_tag_o),
    .res_err_o    (res_err_o)
  );

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ns

module tb_mem_model import lsu_cluster_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  hold_gnt_i,  // keep gnt low while set
  input  logic  req_i,
  output logic  gnt_o,
  input  addr_t addr_i,
  input  logic  we_i,
  input  be_t   be_i,
  input  word_t wdata_i,
  output logic  rvalid_o,
  output logic  err_o,
  output word_t rdata_o
);

  word_t  mem [logic [29:0]];  // sparse, unwritten words come from the fill pattern
  integer seed;
  int     cyc;                 // cycle count, bumped at every rising edge
  int     gnt_wait;            // cycles left before gnt may rise again
  logic   hold_q;
  int     due_q  [$];          // earliest cycle for each pending rvalid
  word_t  data_q [$];
  logic   err_q  [$];

  function automatic word_t fill_word(input logic [29:0] widx);
    return ({widx, 2'b00} * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
  endfunction

  initial begin
    seed     = 32'h8d76_523e;
    cyc      = 0;
    gnt_wait = 0;
    hold_q   = 1'b0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    err_o    = 1'b0;
    rdata_o  = '0;
  end

  // mid-cycle sampling, everything is stable here
  always @(negedge clk) begin
    word_t w;
    hold_q <= hold_gnt_i;
    if (rst_n) begin
      if (rvalid_o) begin  // rvalid consumed at the coming edge
        void'(due_q.pop_front());
        void'(data_q.pop_front());
        void'(err_q.pop_front());
      end
      if (req_i && gnt_o) begin
        w = mem.exists(addr_i[31:2]) ? mem[addr_i[31:2]] : fill_word(addr_i[31:2]);
        if (we_i) begin
          for (int i = 0; i < 4; i++) if (be_i[i]) w[8*i +: 8] = wdata_i[8*i +: 8];
          mem[addr_i[31:2]] = w;
        end
        due_q.push_back(cyc + 1 + ({$random(seed)} % 4));  // 1 to 4 cycles later
        data_q.push_back(w);
        err_q.push_back(addr_i[31:28] == 4'hf);               // error region
        gnt_wait = {$random(seed)} % 4;
      end
    end
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    #2;
    if (!rst_n) begin
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
    end else begin
      if (gnt_wait > 0) begin
        gnt_wait = gnt_wait - 1;
        gnt_o    = 1'b0;
      end else begin
        gnt_o = !hold_q;
      end
      rvalid_o = (due_q.size() > 0) && (due_q[0] <= cyc);  // strictly in order
      rdata_o  = rvalid_o ? data_q[0] : '0;
      err_o    = rvalid_o ? err_q[0] : 1'b0;
    end
  end

endmodule

// ==== tb_lsu_cluster.sv ====
`timescale 1ns/1ns

module tb_lsu_cluster import lsu_cluster_pkg::*; ();

  logic  clk, rst_n;
  logic  op_valid, op_ready, op_we, op_sext;
  size_t op_size;
  addr_t op_base, op_offset;
  word_t op_wdata;
  tag_t  op_tag;
  logic  mem_req, mem_gnt, mem_we, mem_rvalid, mem_err;
  addr_t mem_addr;
  be_t   mem_be;
  word_t mem_wdata, mem_rdata;
  logic  res_valid, res_err;
  word_t res_rdata;
  tag_t  res_tag;
  logic  hold_gnt;

  integer seed;
  int     errors, checks, tests_run, tests_failed, err_mark, max_busy;

  // reference model state, indexed by tag
  logic [2**TAG_W-1:0] pending;
  word_t               exp_data [2**TAG_W];
  logic                exp_err  [2**TAG_W];
  logic                exp_load [2**TAG_W];
  logic [29:0]         tag_w0   [2**TAG_W];  // first word touched
  logic [29:0]         tag_w1   [2**TAG_W];  // last word touched
  word_t               shadow   [logic [29:0]];
  addr_t               gnt_addr_q [$];       // grant log
  be_t                 gnt_be_q   [$];
  logic                gnt_we_q   [$];
  tag_t                mon_tag;

  lsu_cluster_top DUT (
    .clk (clk), .rst_n (rst_n),
    .op_valid_i (op_valid), .op_ready_o (op_ready), .op_we_i (op_we),
    .op_size_i (op_size), .op_sign_ext_i (op_sext), .op_base_i (op_base),
    .op_offset_i (op_offset), .op_wdata_i (op_wdata), .op_tag_i (op_tag),
    .mem_req_o (mem_req), .mem_gnt_i (mem_gnt), .mem_addr_o (mem_addr),
    .mem_we_o (mem_we), .mem_be_o (mem_be), .mem_wdata_o (mem_wdata),
    .mem_rvalid_i (mem_rvalid), .mem_err_i (mem_err), .mem_rdata_i (mem_rdata),
    .res_valid_o (res_valid), .res_rdata_o (res_rdata), .res_tag_o (res_tag),
    .res_err_o (res_err)
  );

  tb_mem_model u_mem (
    .clk (clk), .rst_n (rst_n), .hold_gnt_i (hold_gnt),
    .req_i (mem_req), .gnt_o (mem_gnt), .addr_i (mem_addr), .we_i (mem_we),
    .be_i (mem_be), .wdata_i (mem_wdata), .rvalid_o (mem_rvalid),
    .err_o (mem_err), .rdata_o (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic word_t fill_word(input logic [29:0] widx);
    return ({widx, 2'b00} * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
  endfunction

  function automatic logic [7:0] read_byte(input addr_t a);
    word_t w;
    w = shadow.exists(a[31:2]) ? shadow[a[31:2]] : fill_word(a[31:2]);
    return w[{a[1:0], 3'b000} +: 8];
  endfunction

  function automatic void write_byte(input addr_t a, input logic [7:0] b);
    word_t w;
    w = shadow.exists(a[31:2]) ? shadow[a[31:2]] : fill_word(a[31:2]);
    w[{a[1:0], 3'b000} +: 8] = b;
    shadow[a[31:2]] = w;
  endfunction

  function automatic int nbytes(input size_t size);
    return (size == SIZE_WORD) ? 4 : (size == SIZE_HALF) ? 2 : 1;
  endfunction

  // bytes of the access falling into the first or the next word
  function automatic be_t part_be(input logic [1:0] off, input int n, input bit second);
    be_t b;
    b = '0;
    for (int i = 0; i < 4; i++) begin
      if (!second && (i >= off) && (i < off + n)) b[i] = 1'b1;
      if (second && (i + 4 < off + n)) b[i] = 1'b1;
    end
    return b;
  endfunction

  function automatic bit word_in_use(input logic [29:0] w);
    for (int t = 0; t < 2**TAG_W; t++)
      if (pending[t] && ((tag_w0[t] == w) || (tag_w1[t] == w))) return 1'b1;
    return 1'b0;
  endfunction

  function automatic int find_free_tag();
    for (int t = 0; t < 2**TAG_W; t++) if (!pending[t]) return t;
    return -1;
  endfunction

  task automatic predict(input tag_t t, input logic we, input size_t size, input logic sext,
                         input addr_t addr, input word_t wdata);
    int    n;
    word_t d;
    addr_t last;
    n    = nbytes(size);
    last = addr + n - 1;
    d    = '0;
    for (int i = 0; i < n; i++) begin
      if (we) write_byte(addr + i, wdata[8*i +: 8]);  // low bytes of wdata, little endian
      else    d[8*i +: 8] = read_byte(addr + i);
    end
    if (sext && (n == 2)) d = {{16{d[15]}}, d[15:0]};
    if (sext && (n == 1)) d = {{24{d[7]}}, d[7:0]};
    exp_data[t] = d;
    exp_load[t] = !we;
    exp_err[t]  = (addr[31:28] == 4'hf) || (last[31:28] == 4'hf);  // any word touched
    tag_w0[t]   = addr[31:2];
    tag_w1[t]   = last[31:2];
    pending[t]  = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // checks and helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) tests_failed++;
    $display("test %-26s %s", name, (errors == err_mark) ? "ok" : "failed");
    err_mark = errors;
  endtask

  // called at edge+2, returns at edge+2 after the accepting edge
  task automatic issue_op(input logic we, input size_t size, input logic sext,
                          input addr_t addr, input word_t wdata);
    int    t;
    int    guard;
    word_t off;
    guard = 0;
    t     = find_free_tag();
    while (t < 0) begin
      @(posedge clk);
      #2;
      if (++guard > 500) abort_run("timeout waiting for a free tag");
      t = find_free_tag();
    end
    off       = {$random(seed)} % 64;
    op_valid  = 1'b1;
    op_we     = we;
    op_size   = size;
    op_sext   = sext;
    op_base   = addr - off;  // agu must add it back
    op_offset = off;
    op_wdata  = wdata;
    op_tag    = tag_t'(t);
    guard     = 0;
    #1;
    while (!op_ready) begin  // ready depends on lane state only
      @(posedge clk);
      #3;
      if (++guard > 500) abort_run("timeout waiting for op_ready_o");
    end
    predict(tag_t'(t), we, size, sext, addr, wdata);
    @(posedge clk);
    #2;
    op_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int guard;
    guard = 0;
    while (pending != '0) begin
      @(posedge clk);
      #2;
      if (++guard > 500) abort_run("timeout waiting for outstanding results");
    end
  endtask

  // random address whose words are not in flight
  task automatic pick_addr(input int n, output addr_t a);
    int    guard;
    addr_t last;
    guard = 0;
    forever begin
      a    = 32'h0000_2000 + ({$random(seed)} % 128);
      last = a + n - 1;
      if (!word_in_use(a[31:2]) && !word_in_use(last[31:2])) break;
      @(posedge clk);
      #2;
      if (++guard > 500) abort_run("timeout looking for a free address");
    end
  endtask

  // grants and completions, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && mem_req && mem_gnt) begin
      gnt_addr_q.push_back(mem_addr);
      gnt_be_q.push_back(mem_be);
      gnt_we_q.push_back(mem_we);
    end
    if ($countones(pending) > max_busy) max_busy = $countones(pending);
    if (rst_n && res_valid) begin
      mon_tag = res_tag;
      if (!pending[mon_tag]) begin
        errors++;
        $display("completion for tag %0d which is not outstanding", mon_tag);
      end else begin
        if (exp_load[mon_tag])
          check_value(res_rdata, exp_data[mon_tag], $sformatf("load data tag %0d", mon_tag));
        check_value(res_err, exp_err[mon_tag], $sformatf("err tag %0d", mon_tag));
        pending[mon_tag] = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    addr_t a;
    size_t sz;
    seed = 32'h8d76_523e;
    {errors, checks, tests_run, tests_failed, err_mark, max_busy} = '0;
    pending  = '0;
    rst_n    = 1'b0;
    hold_gnt = 1'b0;
    op_valid = 1'b0;
    op_we    = 1'b0;
    op_size  = SIZE_WORD;
    op_sext  = 1'b0;
    op_base  = '0;
    op_offset = '0;
    op_wdata = '0;
    op_tag   = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    #1;
    check_value(mem_req, 0, "mem_req_o after reset");
    check_value(res_valid, 0, "res_valid_o after reset");
    check_value(op_ready, 1, "op_ready_o after reset");
    @(posedge clk);
    #2;
    end_test("reset state");

    issue_op(1'b1, SIZE_WORD, 1'b0, 32'h0000_0100, 32'hdead_beef);
    wait_idle();
    issue_op(1'b0, SIZE_WORD, 1'b0, 32'h0000_0100, '0);
    wait_idle();
    end_test("aligned store and load");

    issue_op(1'b1, SIZE_WORD, 1'b0, 32'h0000_0300, 32'h80f1_7f82);  // mixed sign bytes
    wait_idle();
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        issue_op(1'b0, SIZE_BYTE, s[0], 32'h0000_0300 + off, '0);
        wait_idle();
        if (off < 3) begin
          issue_op(1'b0, SIZE_HALF, s[0], 32'h0000_0300 + off, '0);
          wait_idle();
        end
      end
    end
    end_test("byte and halfword extension");

    for (int k = 0; k < 8; k++) begin
      a  = 32'h0000_0400 + 16 * k + ((k < 6) ? (k % 3) + 1 : 3);
      sz = (k < 6) ? SIZE_WORD : SIZE_HALF;  // words at offsets 1..3, then halves at 3
      gnt_addr_q.delete();
      gnt_be_q.delete();
      gnt_we_q.delete();
      issue_op(k[0], sz, 1'b1, a, $random(seed));
      wait_idle();
      check_value(gnt_addr_q.size(), 2, "grants of a split access");
      if (gnt_addr_q.size() == 2) begin
        check_value(gnt_addr_q[0], a, "first part address");
        check_value(gnt_be_q[0], part_be(a[1:0], nbytes(sz), 1'b0), "first part be");
        check_value(gnt_we_q[0], k[0], "first part we");
        check_value(gnt_addr_q[1], (a & 32'hffff_fffc) + 32'd4, "second part address");
        check_value(gnt_be_q[1], part_be(a[1:0], nbytes(sz), 1'b1), "second part be");
        check_value(gnt_we_q[1], k[0], "second part we");
      end
      if (k[0]) begin  // load back what the store wrote
        issue_op(1'b0, sz, 1'b0, a, '0);
        wait_idle();
      end
    end
    end_test("misaligned split");

    for (int k = 0; k < 200; k++) begin
      sz = size_t'($random(seed));
      pick_addr(nbytes(sz), a);
      issue_op($random(seed), sz, $random(seed), a, $random(seed));
    end
    wait_idle();
    check_value(max_busy >= 3, 1, "several lanes in flight");
    end_test("random concurrent stream");

    issue_op(1'b0, SIZE_WORD, 1'b0, 32'hf000_0010, '0);
    issue_op(1'b1, SIZE_BYTE, 1'b0, 32'hf000_0021, 32'h0000_005a);
    issue_op(1'b0, SIZE_WORD, 1'b0, 32'hefff_fffe, '0);  // only the next word errs
    issue_op(1'b0, SIZE_WORD, 1'b0, 32'hefff_fff0, '0);
    wait_idle();
    end_test("error region");

    hold_gnt = 1'b1;
    for (int k = 0; k < 4; k++) issue_op(1'b0, SIZE_WORD, 1'b0, 32'h0000_0600 + 8 * k, '0);
    #1;
    check_value(op_ready, 0, "op_ready_o with all lanes busy");
    repeat (5) @(posedge clk);
    #3;
    check_value(op_ready, 0, "op_ready_o under held grant");
    @(posedge clk);
    #2;
    hold_gnt = 1'b0;
    issue_op(1'b1, SIZE_HALF, 1'b0, 32'h0000_0640, 32'h0000_1234);
    wait_idle();
    #1;
    check_value(op_ready, 1, "op_ready_o after drain");
    end_test("grant back-pressure");

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== lsu_cluster.f ====
lsu_cluster_pkg.sv
lsu_op_if.sv
lsu_port_if.sv
lsu_dispatch.sv
lsu_lane.sv
lsu_mem_arbiter.sv
lsu_cluster_top.sv
tb_mem_model.sv
tb_lsu_cluster.sv

// ==== Bender.yml ====
package:
  name: lsu_cluster

sources:
  - lsu_cluster_pkg.sv
  - lsu_op_if.sv
  - lsu_port_if.sv
  - lsu_dispatch.sv
  - lsu_lane.sv
  - lsu_mem_arbiter.sv
  - lsu_cluster_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_lsu_cluster.sv
